/* src/rv_core_pkg.sv */
`default_nettype none

package rv_core_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data or address word
  typedef logic [31:0] word_t;

  // Register index, always 5 bits even for a 16 entry file
  typedef logic [4:0] rf_addr_t;

  ////////////////////////////////////////
  // Opcodes of the supported subset
  ////////////////////////////////////////

  localparam logic [6:0] OPCODE_OP    = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM = 7'h13;
  localparam logic [6:0] OPCODE_LUI   = 7'h37;
  localparam logic [6:0] OPCODE_STORE = 7'h23;

  // ALU operations
  typedef enum logic [1:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_PASS_B
  } alu_op_e;

  // Fetch FSM states
  typedef enum logic [1:0] {
    IF_IDLE,
    IF_REQ,
    IF_WAIT
  } if_state_e;

  ////////////////////////////////////////
  // Pipeline and bus payloads
  ////////////////////////////////////////

  // IF buffer toward decode
  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
  } if_id_pipe_t;

  // ID/EX pipeline register
  typedef struct packed {
    logic     valid;
    alu_op_e  alu_op;
    word_t    operand_a;
    word_t    operand_b;
    rf_addr_t rd;
    logic     rf_we;
    logic     lsu_en;
    word_t    store_wdata;
  } id_ex_pipe_t;

  // OBI request payloads
  typedef struct packed {
    word_t addr;
  } obi_instr_req_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
  } obi_data_req_t;

  // Store handed from EX to the LSU
  typedef struct packed {
    logic  valid;
    word_t addr;
    word_t wdata;
  } lsu_req_t;

endpackage

`default_nettype wire

/* src/rv_register_file.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_register_file import rv_core_pkg::*; #(
  parameter int unsigned NUM_REGS = 32
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  rf_addr_t raddr_a_i,
  input  rf_addr_t raddr_b_i,
  output word_t    rdata_a_o,
  output word_t    rdata_b_o,
  input  logic     we_i,
  input  rf_addr_t waddr_i,
  input  word_t    wdata_i
);

  // x0 has no storage
  word_t regs_q [1:NUM_REGS-1];
  logic  wr_en;

  // Writes to x0 or beyond the file are dropped
  assign wr_en = we_i && waddr_i != '0 && waddr_i < NUM_REGS;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 and unmapped indices read as zero
  assign rdata_a_o = (raddr_a_i != '0 && raddr_a_i < NUM_REGS) ? regs_q[raddr_a_i] : '0;
  assign rdata_b_o = (raddr_b_i != '0 && raddr_b_i < NUM_REGS) ? regs_q[raddr_b_i] : '0;

endmodule

`default_nettype wire

/* src/rv_if_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_if_stage import rv_core_pkg::*; (
  input  logic           clk_i,
  input  logic           arst_n_i,
  input  word_t          boot_addr_i,
  input  logic           fetch_enable_i,
  // OBI instruction port
  output logic           instr_req_o,
  output obi_instr_req_t instr_addr_o,
  input  logic           instr_gnt_i,
  input  logic           instr_rvalid_i,
  input  word_t          instr_rdata_i,
  // Toward decode
  output if_id_pipe_t    if_id_pipe_o,
  input  logic           id_ready_i
);

  if_state_e   state_q;
  if_state_e   state_d;
  logic        fetch_en_q;
  logic        buf_free;
  word_t       pc_q;
  if_id_pipe_t buf_q;

  // Buffer is empty next cycle
  assign buf_free = ~buf_q.valid | id_ready_i;

  ////////////////////////////////////////
  // Fetch FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      // Waits for the enable or for room in the buffer
      IF_IDLE: begin
        if ((fetch_en_q || fetch_enable_i) && buf_free) begin
          state_d = IF_REQ;
        end
      end
      // Request held until grant
      IF_REQ: begin
        if (instr_gnt_i) begin
          state_d = IF_WAIT;
        end
      end
      IF_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = IF_IDLE;
        end
      end
      default: state_d = IF_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= IF_IDLE;
      fetch_en_q <= 1'b0;
      pc_q       <= '0;
    end else begin
      state_q    <= state_d;
      // Sticky enable, the level may drop later
      fetch_en_q <= fetch_en_q | fetch_enable_i;
      if (fetch_enable_i && !fetch_en_q) begin
        pc_q <= boot_addr_i;
      end else if (state_q == IF_REQ && instr_gnt_i) begin
        pc_q <= pc_q + 32'd4;
      end
    end
  end

  ////////////////////////////////////////
  // Instruction buffer
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      buf_q <= '0;
    end else if (state_q == IF_WAIT && instr_rvalid_i) begin
      buf_q.valid <= 1'b1;
      buf_q.instr <= instr_rdata_i;
      // pc_q already stepped on grant
      buf_q.pc    <= pc_q - 32'd4;
    end else if (id_ready_i) begin
      buf_q.valid <= 1'b0;
    end
  end

  assign instr_req_o       = (state_q == IF_REQ);
  assign instr_addr_o.addr = pc_q;
  assign if_id_pipe_o      = buf_q;

endmodule

`default_nettype wire

/* src/rv_id_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_id_stage import rv_core_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  if_id_pipe_t if_id_pipe_i,
  output logic        id_ready_o,
  // Register file read ports
  output rf_addr_t    rf_raddr_a_o,
  output rf_addr_t    rf_raddr_b_o,
  input  word_t       rf_rdata_a_i,
  input  word_t       rf_rdata_b_i,
  // Forwarding from EX
  input  logic        fwd_we_i,
  input  rf_addr_t    fwd_waddr_i,
  input  word_t       fwd_wdata_i,
  // Toward EX
  output id_ex_pipe_t id_ex_pipe_o,
  input  logic        ex_ready_i
);

  word_t       instr;
  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  rf_addr_t    rs1;
  rf_addr_t    rs2;
  rf_addr_t    rd;
  word_t       imm_i;
  word_t       imm_s;
  word_t       imm_u;
  word_t       rs1_val;
  word_t       rs2_val;
  id_ex_pipe_t dec;
  id_ex_pipe_t pipe_q;

  // Instruction fields
  assign instr  = if_id_pipe_i.instr;
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  // Immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000};

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  ////////////////////////////////////////
  // Operand forwarding
  ////////////////////////////////////////

  // EX writes this cycle, the file still holds the old value
  assign rs1_val = (fwd_we_i && fwd_waddr_i == rs1 && rs1 != '0) ? fwd_wdata_i : rf_rdata_a_i;
  assign rs2_val = (fwd_we_i && fwd_waddr_i == rs2 && rs2 != '0) ? fwd_wdata_i : rf_rdata_b_i;

  ////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////

  always_comb begin
    dec             = '0;
    dec.valid       = if_id_pipe_i.valid;
    dec.alu_op      = ALU_ADD;
    dec.operand_a   = rs1_val;
    dec.operand_b   = rs2_val;
    dec.rd          = rd;
    dec.store_wdata = rs2_val;
    case (opcode)
      // ADDI only
      OPCODE_OPIMM: begin
        if (funct3 == 3'b000) begin
          dec.operand_b = imm_i;
          dec.rf_we     = 1'b1;
        end
      end
      // ADD and SUB
      OPCODE_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          dec.rf_we = 1'b1;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          dec.alu_op = ALU_SUB;
          dec.rf_we  = 1'b1;
        end
      end
      OPCODE_LUI: begin
        dec.alu_op    = ALU_PASS_B;
        dec.operand_b = imm_u;
        dec.rf_we     = 1'b1;
      end
      // SW, address is rs1 plus offset
      OPCODE_STORE: begin
        if (funct3 == 3'b010) begin
          dec.operand_b = imm_s;
          dec.lsu_en    = 1'b1;
        end
      end
      // Anything else retires as a no-op
      default: ;
    endcase
  end

  // Consume only when the ID/EX register can load
  assign id_ready_o = ex_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pipe_q <= '0;
    end else if (ex_ready_i) begin
      pipe_q <= dec;
    end
  end

  assign id_ex_pipe_o = pipe_q;

endmodule

`default_nettype wire

/* src/rv_ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_ex_stage import rv_core_pkg::*; (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  id_ex_pipe_t id_ex_pipe_i,
  output logic        ex_ready_o,
  // Write-back, also forwarded to ID
  output logic        rf_we_o,
  output rf_addr_t    rf_waddr_o,
  output word_t       rf_wdata_o,
  // Store hand-off
  output lsu_req_t    lsu_req_o,
  input  logic        lsu_ready_i
);

  word_t alu_result;
  logic  store_hold;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  always_comb begin
    unique case (id_ex_pipe_i.alu_op)
      ALU_ADD:    alu_result = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
      ALU_SUB:    alu_result = id_ex_pipe_i.operand_a - id_ex_pipe_i.operand_b;
      ALU_PASS_B: alu_result = id_ex_pipe_i.operand_b;
      default:    alu_result = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
    endcase
  end

  ////////////////////////////////////////
  // Write-back
  ////////////////////////////////////////

  // Same cycle as the entry sits in EX
  assign rf_we_o    = id_ex_pipe_i.valid & id_ex_pipe_i.rf_we;
  assign rf_waddr_o = id_ex_pipe_i.rd;
  assign rf_wdata_o = alu_result;

  ////////////////////////////////////////
  // Store hand-off
  ////////////////////////////////////////

  assign lsu_req_o.valid = id_ex_pipe_i.valid & id_ex_pipe_i.lsu_en;
  assign lsu_req_o.addr  = alu_result;
  assign lsu_req_o.wdata = id_ex_pipe_i.store_wdata;

  // Store waits in EX while the LSU is busy
  assign store_hold = lsu_req_o.valid & ~lsu_ready_i;
  assign ex_ready_o = ~store_hold;

endmodule

`default_nettype wire

/* src/rv_load_store_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_load_store_unit import rv_core_pkg::*; (
  input  logic          clk_i,
  input  logic          arst_n_i,
  // From EX
  input  lsu_req_t      lsu_req_i,
  output logic          lsu_ready_o,
  // OBI data port, word stores
  output logic          data_req_o,
  output obi_data_req_t data_obi_o,
  input  logic          data_gnt_i,
  input  logic          data_rvalid_i
);

  logic          req_q;
  logic          outstanding_q;
  logic          accept;
  obi_data_req_t obi_q;

  // Idle means no request up and nothing in flight
  assign lsu_ready_o = ~req_q & ~outstanding_q;
  assign accept      = lsu_req_i.valid & lsu_ready_o;

  ////////////////////////////////////////
  // Transaction tracking
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q         <= 1'b0;
      outstanding_q <= 1'b0;
    end else begin
      if (accept) begin
        req_q <= 1'b1;
      end else if (req_q && data_gnt_i) begin
        // Address phase done, response pending
        req_q         <= 1'b0;
        outstanding_q <= 1'b1;
      end
      if (outstanding_q && data_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // Payload stays put until grant
  always_ff @(posedge clk_i) begin
    if (accept) begin
      obi_q.addr  <= lsu_req_i.addr;
      obi_q.wdata <= lsu_req_i.wdata;
    end
  end

  assign data_req_o = req_q;
  assign data_obi_o = obi_q;

endmodule

`default_nettype wire

/* src/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_core_pkg::*; #(
  parameter int unsigned NUM_REGS = 32
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  input  word_t boot_addr_i,
  input  logic  fetch_enable_i,
  // Instruction port
  output logic  instr_req_o,
  output word_t instr_addr_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  input  word_t instr_rdata_i,
  // Data port
  output logic  data_req_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i
);

  // Stage to stage
  if_id_pipe_t    if_id_pipe;
  id_ex_pipe_t    id_ex_pipe;
  lsu_req_t       lsu_req;
  logic           id_ready;
  logic           ex_ready;
  logic           lsu_ready;

  // Register file
  rf_addr_t       rf_raddr_a;
  rf_addr_t       rf_raddr_b;
  word_t          rf_rdata_a;
  word_t          rf_rdata_b;
  logic           rf_we;
  rf_addr_t       rf_waddr;
  word_t          rf_wdata;

  // OBI payloads
  obi_instr_req_t instr_obi;
  obi_data_req_t  data_obi;

  assign instr_addr_o = instr_obi.addr;
  assign data_addr_o  = data_obi.addr;
  assign data_wdata_o = data_obi.wdata;

  ////////////////////////////////////////
  // IF stage
  ////////////////////////////////////////

  rv_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_obi      ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .if_id_pipe_o   ( if_id_pipe     ),
    .id_ready_i     ( id_ready       )
  );

  ////////////////////////////////////////
  // ID stage
  ////////////////////////////////////////

  rv_id_stage id_stage_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .if_id_pipe_i   ( if_id_pipe     ),
    .id_ready_o     ( id_ready       ),
    .rf_raddr_a_o   ( rf_raddr_a     ),
    .rf_raddr_b_o   ( rf_raddr_b     ),
    .rf_rdata_a_i   ( rf_rdata_a     ),
    .rf_rdata_b_i   ( rf_rdata_b     ),
    .fwd_we_i       ( rf_we          ),
    .fwd_waddr_i    ( rf_waddr       ),
    .fwd_wdata_i    ( rf_wdata       ),
    .id_ex_pipe_o   ( id_ex_pipe     ),
    .ex_ready_i     ( ex_ready       )
  );

  ////////////////////////////////////////
  // EX stage, also write-back
  ////////////////////////////////////////

  rv_ex_stage ex_stage_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .id_ex_pipe_i   ( id_ex_pipe     ),
    .ex_ready_o     ( ex_ready       ),
    .rf_we_o        ( rf_we          ),
    .rf_waddr_o     ( rf_waddr       ),
    .rf_wdata_o     ( rf_wdata       ),
    .lsu_req_o      ( lsu_req        ),
    .lsu_ready_i    ( lsu_ready      )
  );

  // Store path to the data port
  rv_load_store_unit load_store_unit_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .lsu_req_i      ( lsu_req        ),
    .lsu_ready_o    ( lsu_ready      ),
    .data_req_o     ( data_req_o     ),
    .data_obi_o     ( data_obi       ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  )
  );

  rv_register_file #(
    .NUM_REGS       ( NUM_REGS       )
  ) register_file_i (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .raddr_a_i      ( rf_raddr_a     ),
    .raddr_b_i      ( rf_raddr_b     ),
    .rdata_a_o      ( rf_rdata_a     ),
    .rdata_b_o      ( rf_rdata_b     ),
    .we_i           ( rf_we          ),
    .waddr_i        ( rf_waddr       ),
    .wdata_i        ( rf_wdata       )
  );

endmodule

`default_nettype wire

/* test/rv_core_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_asserts import rv_core_pkg::*; (
  input logic  clk_i,
  input logic  arst_n_i,
  input logic  instr_req_o,
  input word_t instr_addr_o,
  input logic  instr_gnt_i,
  input logic  data_req_o,
  input word_t data_addr_o,
  input word_t data_wdata_o,
  input logic  data_gnt_i,
  input logic  data_rvalid_i
);

  int   fail_cnt = 0;
  logic data_pend_q;

  // Granted store still waiting for rvalid
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      data_pend_q <= 1'b0;
    end else if (data_req_o && data_gnt_i) begin
      data_pend_q <= 1'b1;
    end else if (data_rvalid_i) begin
      data_pend_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Protocol rules
  ////////////////////////////////////////

  // Both ports quiet in and right after reset
  reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i || $rose(arst_n_i) |-> !instr_req_o && !data_req_o)
    else begin
      fail_cnt++;
      $error("request raised during or just after reset");
    end

  instr_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else begin
      fail_cnt++;
      $error("instruction request dropped or changed before grant");
    end

  data_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_wdata_o))
    else begin
      fail_cnt++;
      $error("data request dropped or changed before grant");
    end

  // One store in flight at a time, no new request before the rvalid
  data_single: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    data_req_o |-> !data_pend_q)
    else begin
      fail_cnt++;
      $error("second store requested before the previous rvalid");
    end

endmodule

bind rv_core rv_core_asserts asserts_i (
  .clk_i         ( clk_i         ),
  .arst_n_i      ( arst_n_i      ),
  .instr_req_o   ( instr_req_o   ),
  .instr_addr_o  ( instr_addr_o  ),
  .instr_gnt_i   ( instr_gnt_i   ),
  .data_req_o    ( data_req_o    ),
  .data_addr_o   ( data_addr_o   ),
  .data_wdata_o  ( data_wdata_o  ),
  .data_gnt_i    ( data_gnt_i    ),
  .data_rvalid_i ( data_rvalid_i )
);

`default_nettype wire

/* test/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  localparam int          NUM_REGS  = 16;
  localparam int          PROG_LEN  = 240;
  localparam logic [31:0] BOOT_ADDR = 32'h0000_1000;
  localparam int          TIMEOUT   = 20000;

  logic        clk_i = 1'b0;
  logic        arst_n_i;
  logic [31:0] boot_addr_i;
  logic        fetch_enable_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        data_req_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        data_gnt_i;
  logic        data_rvalid_i;

  // Program image and expected stores, {addr, data}
  logic [31:0] prog_mem [PROG_LEN];
  logic [63:0] store_q [$];
  logic [31:0] lfsr_q;
  logic [31:0] fetch_exp = BOOT_ADDR;
  logic [31:0] i_addr;
  logic        en_seen = 1'b0;
  logic        i_pend = 1'b0;
  logic        d_pend = 1'b0;
  int          i_dly = 0;
  int          d_dly = 0;
  int          n_exp = 0;
  int          store_cnt = 0;
  int          store_err = 0;
  int          fetch_err = 0;
  int          timeout_cnt = 0;

  always #50 clk_i = ~clk_i;

  rv_core #(
    .NUM_REGS       ( NUM_REGS       )
  ) DUT (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .boot_addr_i    ( boot_addr_i    ),
    .fetch_enable_i ( fetch_enable_i ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .data_req_o     ( data_req_o     ),
    .data_addr_o    ( data_addr_o    ),
    .data_wdata_o   ( data_wdata_o   ),
    .data_gnt_i     ( data_gnt_i     ),
    .data_rvalid_i  ( data_rvalid_i  )
  );

  ////////////////////////////////////////
  // Random source
  ////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // Program and reference model
  ////////////////////////////////////////

  task automatic build_program();
    logic [2:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    for (int i = 0; i < PROG_LEN; i++) begin
      kind = 3'(rand_bits(3));
      // Registers x0 to x7 only
      rd   = 5'(rand_bits(3));
      rs1  = 5'(rand_bits(3));
      rs2  = 5'(rand_bits(3));
      imm  = rand_bits(30);
      case (kind)
        3'd0, 3'd1: prog_mem[i] = {imm[11:0], rs1, 3'b000, rd, 7'h13};
        3'd2:       prog_mem[i] = {7'h00, rs2, rs1, 3'b000, rd, 7'h33};
        3'd3:       prog_mem[i] = {7'h20, rs2, rs1, 3'b000, rd, 7'h33};
        3'd4:       prog_mem[i] = {imm[19:0], rd, 7'h37};
        3'd5, 3'd6: prog_mem[i] = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
        // Low bits 00 never form a valid opcode
        default:    prog_mem[i] = {imm[29:0], 2'b00};
      endcase
    end
  endtask

  // In-order ISA execution of the subset, everything else a no-op
  task automatic run_model();
    logic [31:0] regs [32];
    logic [31:0] w;
    logic [31:0] res;
    logic        wr;
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    for (int i = 0; i < PROG_LEN; i++) begin
      w   = prog_mem[i];
      wr  = 1'b0;
      res = '0;
      if (w[6:0] == 7'h13 && w[14:12] == 3'b000) begin
        res = regs[w[19:15]] + {{20{w[31]}}, w[31:20]};
        wr  = 1'b1;
      end else if (w[6:0] == 7'h33 && w[14:12] == 3'b000 && w[31:25] == 7'h00) begin
        res = regs[w[19:15]] + regs[w[24:20]];
        wr  = 1'b1;
      end else if (w[6:0] == 7'h33 && w[14:12] == 3'b000 && w[31:25] == 7'h20) begin
        res = regs[w[19:15]] - regs[w[24:20]];
        wr  = 1'b1;
      end else if (w[6:0] == 7'h37) begin
        res = {w[31:12], 12'h000};
        wr  = 1'b1;
      end else if (w[6:0] == 7'h23 && w[14:12] == 3'b010) begin
        store_q.push_back({regs[w[19:15]] + {{20{w[31]}}, w[31:25], w[11:7]},
                           regs[w[24:20]]});
      end
      // x0 stays zero
      if (wr && w[11:7] != 5'd0) begin
        regs[w[11:7]] = res;
      end
    end
  endtask

  // Past the program end a word equals its address, an undefined encoding
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] idx;
    idx = (addr - BOOT_ADDR) >> 2;
    if (addr >= BOOT_ADDR && idx < PROG_LEN) begin
      return prog_mem[idx];
    end
    return addr;
  endfunction

  task automatic check_store();
    logic [63:0] exp;
    store_cnt++;
    if (store_q.size() == 0) begin
      store_err++;
      $display("Error at %0t: unexpected store to %h data %h", $time, data_addr_o,
               data_wdata_o);
    end else begin
      exp = store_q.pop_front();
      assert (data_addr_o == exp[63:32]) else begin
        store_err++;
        $display("Error at %0t: store address %h, expected %h", $time, data_addr_o,
                 exp[63:32]);
      end
      assert (data_wdata_o == exp[31:0]) else begin
        store_err++;
        $display("Error at %0t: store data %h, expected %h", $time, data_wdata_o,
                 exp[31:0]);
      end
    end
  endtask

  ////////////////////////////////////////
  // OBI responders, both ports
  ////////////////////////////////////////

  always @(posedge clk_i) begin
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    data_gnt_i     <= 1'b0;
    data_rvalid_i  <= 1'b0;
    if (arst_n_i) begin
      assert (!instr_req_o || en_seen) else begin
        fetch_err++;
        $display("Error at %0t: instruction request before fetch enable", $time);
      end
      if (fetch_enable_i) begin
        en_seen = 1'b1;
      end
      // Instruction port, handshake seen at this edge
      if (instr_req_o && instr_gnt_i) begin
        assert (instr_addr_o == fetch_exp) else begin
          fetch_err++;
          $display("Error at %0t: fetch address %h, expected %h", $time, instr_addr_o,
                   fetch_exp);
        end
        fetch_exp = fetch_exp + 32'd4;
        i_addr    = instr_addr_o;
        i_pend    = 1'b1;
        i_dly     = rand_bits(2);
      end else if (i_pend) begin
        if (i_dly == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= fetch_word(i_addr);
          i_pend = 1'b0;
          i_dly  = rand_bits(2);
        end else begin
          i_dly--;
        end
      end else if (instr_req_o) begin
        if (i_dly == 0) begin
          instr_gnt_i <= 1'b1;
        end else begin
          i_dly--;
        end
      end
      // Data port
      if (data_req_o && data_gnt_i) begin
        check_store();
        d_pend = 1'b1;
        d_dly  = rand_bits(2);
      end else if (d_pend) begin
        if (d_dly == 0) begin
          data_rvalid_i <= 1'b1;
          d_pend = 1'b0;
          d_dly  = rand_bits(2);
        end else begin
          d_dly--;
        end
      end else if (data_req_o) begin
        if (d_dly == 0) begin
          data_gnt_i <= 1'b1;
        end else begin
          d_dly--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////

  initial begin
    int cycles;
    int total;
    arst_n_i       = 1'b0;
    boot_addr_i    = BOOT_ADDR;
    fetch_enable_i = 1'b0;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    lfsr_q         = 32'h81fa;
    build_program();
    run_model();
    n_exp = store_q.size();

    repeat (16) @(posedge clk_i);
    arst_n_i <= 1'b1;
    // Idle stretch, no fetch yet
    repeat (8) @(posedge clk_i);
    fetch_enable_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    // Level drops, core keeps going
    fetch_enable_i <= 1'b0;

    // Sampled mid-cycle, away from the responder edge
    cycles = 0;
    while (store_cnt < n_exp && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (store_cnt < n_exp) begin
      timeout_cnt++;
      $display("Timeout: only %0d of %0d stores were granted", store_cnt, n_exp);
    end

    // Run past the program end so stray stores would show
    cycles = 0;
    while (fetch_exp < BOOT_ADDR + 4 * PROG_LEN + 64 && cycles < TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (fetch_exp < BOOT_ADDR + 4 * PROG_LEN + 64) begin
      timeout_cnt++;
      $display("Timeout: fetching stalled at address %h", fetch_exp);
    end

    total = store_err + fetch_err + timeout_cnt + DUT.asserts_i.fail_cnt;
    $display("Stores %0d of %0d, store errors %0d, fetch errors %0d, protocol errors %0d, timeouts %0d",
             store_cnt, n_exp, store_err, fetch_err, DUT.asserts_i.fail_cnt, timeout_cnt);
    if (total == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/rv_core_pkg.sv
src/rv_register_file.sv
src/rv_if_stage.sv
src/rv_id_stage.sv
src/rv_ex_stage.sv
src/rv_load_store_unit.sv
src/rv_core.sv
test/rv_core_asserts.sv
test/tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - src/rv_core_pkg.sv
  - src/rv_register_file.sv
  - src/rv_if_stage.sv
  - src/rv_id_stage.sv
  - src/rv_ex_stage.sv
  - src/rv_load_store_unit.sv
  - src/rv_core.sv
  - target: test
    files:
      - test/rv_core_asserts.sv
      - test/tb_rv_core.sv
